//--- Makefile
VERILATOR ?= verilator
TOP       ?= axi_lite_cut_chain_tb
FILELIST  ?= axi_lite_cut_chain.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axi_lite_cut_chain.f
src/axi_lite_cut_pkg.sv
src/spill_register.sv
src/axi_lite_cut.sv
src/axi_lite_regfile.sv
src/axi_lite_cut_chain.sv
test/axi_lite_cut_chain_props.sv
test/axi_lite_cut_chain_tb.sv

//--- src/axi_lite_cut.sv
`timescale 1ns/10ps

module axi_lite_cut #(
  parameter bit bypass = 1'b0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Slave side
  input  logic                     slv_aw_valid_i,
  output logic                     slv_aw_ready_o,
  input  axi_lite_cut_pkg::addr_t  slv_aw_addr_i,
  input  logic                     slv_w_valid_i,
  output logic                     slv_w_ready_o,
  input  axi_lite_cut_pkg::data_t  slv_w_data_i,
  input  axi_lite_cut_pkg::strb_t  slv_w_strb_i,
  output logic                     slv_b_valid_o,
  input  logic                     slv_b_ready_i,
  output axi_lite_cut_pkg::resp_t  slv_b_resp_o,
  input  logic                     slv_ar_valid_i,
  output logic                     slv_ar_ready_o,
  input  axi_lite_cut_pkg::addr_t  slv_ar_addr_i,
  output logic                     slv_r_valid_o,
  input  logic                     slv_r_ready_i,
  output axi_lite_cut_pkg::data_t  slv_r_data_o,
  output axi_lite_cut_pkg::resp_t  slv_r_resp_o,
  // Master side
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  output axi_lite_cut_pkg::addr_t  mst_aw_addr_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  output axi_lite_cut_pkg::data_t  mst_w_data_o,
  output axi_lite_cut_pkg::strb_t  mst_w_strb_o,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o,
  input  axi_lite_cut_pkg::resp_t  mst_b_resp_i,
  output logic                     mst_ar_valid_o,
  input  logic                     mst_ar_ready_i,
  output axi_lite_cut_pkg::addr_t  mst_ar_addr_o,
  input  logic                     mst_r_valid_i,
  output logic                     mst_r_ready_o,
  input  axi_lite_cut_pkg::data_t  mst_r_data_i,
  input  axi_lite_cut_pkg::resp_t  mst_r_resp_i
);

  localparam int unsigned addr_w = $bits(axi_lite_cut_pkg::addr_t);
  localparam int unsigned w_w    = $bits(axi_lite_cut_pkg::data_t)
                                 + $bits(axi_lite_cut_pkg::strb_t);
  localparam int unsigned b_w    = $bits(axi_lite_cut_pkg::resp_t);
  localparam int unsigned r_w    = $bits(axi_lite_cut_pkg::data_t)
                                 + $bits(axi_lite_cut_pkg::resp_t);

  // Packed payloads for the W and R channels
  logic [w_w-1:0] w_slv, w_mst;
  logic [r_w-1:0] r_slv, r_mst;

  assign w_slv = {slv_w_data_i, slv_w_strb_i};
  assign {mst_w_data_o, mst_w_strb_o} = w_mst;
  assign r_mst = {mst_r_data_i, mst_r_resp_i};
  assign {slv_r_data_o, slv_r_resp_o} = r_slv;

  // Request channels run slave to master
  spill_register #(.width(addr_w), .bypass(bypass)) aw_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_aw_valid_i),
    .ready_o (slv_aw_ready_o),
    .data_i  (slv_aw_addr_i),
    .valid_o (mst_aw_valid_o),
    .ready_i (mst_aw_ready_i),
    .data_o  (mst_aw_addr_o)
  );

  spill_register #(.width(w_w), .bypass(bypass)) w_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_w_valid_i),
    .ready_o (slv_w_ready_o),
    .data_i  (w_slv),
    .valid_o (mst_w_valid_o),
    .ready_i (mst_w_ready_i),
    .data_o  (w_mst)
  );

  spill_register #(.width(addr_w), .bypass(bypass)) ar_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (slv_ar_valid_i),
    .ready_o (slv_ar_ready_o),
    .data_i  (slv_ar_addr_i),
    .valid_o (mst_ar_valid_o),
    .ready_i (mst_ar_ready_i),
    .data_o  (mst_ar_addr_o)
  );

  // Response channels run master to slave
  spill_register #(.width(b_w), .bypass(bypass)) b_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (mst_b_valid_i),
    .ready_o (mst_b_ready_o),
    .data_i  (mst_b_resp_i),
    .valid_o (slv_b_valid_o),
    .ready_i (slv_b_ready_i),
    .data_o  (slv_b_resp_o)
  );

  spill_register #(.width(r_w), .bypass(bypass)) r_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (mst_r_valid_i),
    .ready_o (mst_r_ready_o),
    .data_i  (r_mst),
    .valid_o (slv_r_valid_o),
    .ready_i (slv_r_ready_i),
    .data_o  (r_slv)
  );

endmodule

//--- src/axi_lite_cut_chain.sv
`timescale 1ns/10ps

module axi_lite_cut_chain #(
  parameter int unsigned num_cuts = 2,
  parameter bit          bypass   = 1'b0,
  parameter int unsigned num_regs = 8
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  axi_lite_cut_pkg::addr_t  aw_addr_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  input  axi_lite_cut_pkg::data_t  w_data_i,
  input  axi_lite_cut_pkg::strb_t  w_strb_i,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output axi_lite_cut_pkg::resp_t  b_resp_o,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  axi_lite_cut_pkg::addr_t  ar_addr_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output axi_lite_cut_pkg::data_t  r_data_o,
  output axi_lite_cut_pkg::resp_t  r_resp_o
);

  // Stage 0 is the port, stage num_cuts feeds the register file
  logic                    aw_valid [num_cuts+1];
  logic                    aw_ready [num_cuts+1];
  axi_lite_cut_pkg::addr_t aw_addr  [num_cuts+1];
  logic                    w_valid  [num_cuts+1];
  logic                    w_ready  [num_cuts+1];
  axi_lite_cut_pkg::data_t w_data   [num_cuts+1];
  axi_lite_cut_pkg::strb_t w_strb   [num_cuts+1];
  logic                    b_valid  [num_cuts+1];
  logic                    b_ready  [num_cuts+1];
  axi_lite_cut_pkg::resp_t b_resp   [num_cuts+1];
  logic                    ar_valid [num_cuts+1];
  logic                    ar_ready [num_cuts+1];
  axi_lite_cut_pkg::addr_t ar_addr  [num_cuts+1];
  logic                    r_valid  [num_cuts+1];
  logic                    r_ready  [num_cuts+1];
  axi_lite_cut_pkg::data_t r_data   [num_cuts+1];
  axi_lite_cut_pkg::resp_t r_resp   [num_cuts+1];

  assign aw_valid[0] = aw_valid_i;
  assign aw_addr[0]  = aw_addr_i;
  assign w_valid[0]  = w_valid_i;
  assign w_data[0]   = w_data_i;
  assign w_strb[0]   = w_strb_i;
  assign b_ready[0]  = b_ready_i;
  assign ar_valid[0] = ar_valid_i;
  assign ar_addr[0]  = ar_addr_i;
  assign r_ready[0]  = r_ready_i;
  assign aw_ready_o  = aw_ready[0];
  assign w_ready_o   = w_ready[0];
  assign b_valid_o   = b_valid[0];
  assign b_resp_o    = b_resp[0];
  assign ar_ready_o  = ar_ready[0];
  assign r_valid_o   = r_valid[0];
  assign r_data_o    = r_data[0];
  assign r_resp_o    = r_resp[0];

  for (genvar k = 0; k < num_cuts; k++) begin : gen_cut
    axi_lite_cut #(.bypass(bypass)) cut_inst (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .slv_aw_valid_i (aw_valid[k]),
      .slv_aw_ready_o (aw_ready[k]),
      .slv_aw_addr_i  (aw_addr[k]),
      .slv_w_valid_i  (w_valid[k]),
      .slv_w_ready_o  (w_ready[k]),
      .slv_w_data_i   (w_data[k]),
      .slv_w_strb_i   (w_strb[k]),
      .slv_b_valid_o  (b_valid[k]),
      .slv_b_ready_i  (b_ready[k]),
      .slv_b_resp_o   (b_resp[k]),
      .slv_ar_valid_i (ar_valid[k]),
      .slv_ar_ready_o (ar_ready[k]),
      .slv_ar_addr_i  (ar_addr[k]),
      .slv_r_valid_o  (r_valid[k]),
      .slv_r_ready_i  (r_ready[k]),
      .slv_r_data_o   (r_data[k]),
      .slv_r_resp_o   (r_resp[k]),
      .mst_aw_valid_o (aw_valid[k+1]),
      .mst_aw_ready_i (aw_ready[k+1]),
      .mst_aw_addr_o  (aw_addr[k+1]),
      .mst_w_valid_o  (w_valid[k+1]),
      .mst_w_ready_i  (w_ready[k+1]),
      .mst_w_data_o   (w_data[k+1]),
      .mst_w_strb_o   (w_strb[k+1]),
      .mst_b_valid_i  (b_valid[k+1]),
      .mst_b_ready_o  (b_ready[k+1]),
      .mst_b_resp_i   (b_resp[k+1]),
      .mst_ar_valid_o (ar_valid[k+1]),
      .mst_ar_ready_i (ar_ready[k+1]),
      .mst_ar_addr_o  (ar_addr[k+1]),
      .mst_r_valid_i  (r_valid[k+1]),
      .mst_r_ready_o  (r_ready[k+1]),
      .mst_r_data_i   (r_data[k+1]),
      .mst_r_resp_i   (r_resp[k+1])
    );
  end

  // Terminating slave at the end of the chain
  axi_lite_regfile #(.num_regs(num_regs)) regfile_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .aw_valid_i (aw_valid[num_cuts]),
    .aw_ready_o (aw_ready[num_cuts]),
    .aw_addr_i  (aw_addr[num_cuts]),
    .w_valid_i  (w_valid[num_cuts]),
    .w_ready_o  (w_ready[num_cuts]),
    .w_data_i   (w_data[num_cuts]),
    .w_strb_i   (w_strb[num_cuts]),
    .b_valid_o  (b_valid[num_cuts]),
    .b_ready_i  (b_ready[num_cuts]),
    .b_resp_o   (b_resp[num_cuts]),
    .ar_valid_i (ar_valid[num_cuts]),
    .ar_ready_o (ar_ready[num_cuts]),
    .ar_addr_i  (ar_addr[num_cuts]),
    .r_valid_o  (r_valid[num_cuts]),
    .r_ready_i  (r_ready[num_cuts]),
    .r_data_o   (r_data[num_cuts]),
    .r_resp_o   (r_resp[num_cuts])
  );

endmodule

//--- src/axi_lite_cut_pkg.sv
package axi_lite_cut_pkg;

  // Bus widths
  typedef logic [11:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // AXI response codes
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // Register file write channel FSM
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  // Register file read channel FSM
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage

//--- src/axi_lite_regfile.sv
`timescale 1ns/10ps

module axi_lite_regfile #(
  parameter int unsigned num_regs = 8
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  axi_lite_cut_pkg::addr_t  aw_addr_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  input  axi_lite_cut_pkg::data_t  w_data_i,
  input  axi_lite_cut_pkg::strb_t  w_strb_i,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output axi_lite_cut_pkg::resp_t  b_resp_o,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  axi_lite_cut_pkg::addr_t  ar_addr_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output axi_lite_cut_pkg::data_t  r_data_o,
  output axi_lite_cut_pkg::resp_t  r_resp_o
);

  localparam int unsigned addr_w = $bits(axi_lite_cut_pkg::addr_t);
  localparam int unsigned strb_w = $bits(axi_lite_cut_pkg::strb_t);
  localparam int unsigned idx_w  = (num_regs > 1) ? $clog2(num_regs) : 1;

  axi_lite_cut_pkg::data_t   regs_q [num_regs];
  axi_lite_cut_pkg::wr_state_e wr_state_q;
  axi_lite_cut_pkg::rd_state_e rd_state_q;
  axi_lite_cut_pkg::resp_t   b_resp_q;
  axi_lite_cut_pkg::resp_t   r_resp_q;
  axi_lite_cut_pkg::data_t   r_data_q;

  logic [addr_w-3:0] wr_word, rd_word;
  logic [idx_w-1:0]  wr_idx, rd_idx;
  logic              wr_in_range, rd_in_range;
  logic              wr_fire, rd_fire;

  // Word index, byte offset bits ignored
  assign wr_word     = aw_addr_i[addr_w-1:2];
  assign rd_word     = ar_addr_i[addr_w-1:2];
  assign wr_idx      = aw_addr_i[idx_w+1:2];
  assign rd_idx      = ar_addr_i[idx_w+1:2];
  assign wr_in_range = (wr_word < num_regs);
  assign rd_in_range = (rd_word < num_regs);

  // AW and W are taken together in one cycle
  assign wr_fire    = aw_valid_i & w_valid_i & (wr_state_q == axi_lite_cut_pkg::WR_IDLE);
  assign aw_ready_o = wr_fire;
  assign w_ready_o  = wr_fire;
  assign b_valid_o  = (wr_state_q == axi_lite_cut_pkg::WR_RESP);
  assign b_resp_o   = b_resp_q;

  assign ar_ready_o = (rd_state_q == axi_lite_cut_pkg::RD_IDLE);
  assign rd_fire    = ar_valid_i & ar_ready_o;
  assign r_valid_o  = (rd_state_q == axi_lite_cut_pkg::RD_RESP);
  assign r_data_o   = r_data_q;
  assign r_resp_o   = r_resp_q;

  // Register array with per byte lane update
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_fire && wr_in_range) begin
      for (int b = 0; b < strb_w; b++) begin
        if (w_strb_i[b]) begin
          regs_q[wr_idx][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
  end

  // Write channel FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= axi_lite_cut_pkg::WR_IDLE;
    end else begin
      case (wr_state_q)
        axi_lite_cut_pkg::WR_IDLE: if (wr_fire) wr_state_q <= axi_lite_cut_pkg::WR_RESP;
        axi_lite_cut_pkg::WR_RESP: if (b_ready_i) wr_state_q <= axi_lite_cut_pkg::WR_IDLE;
        default: wr_state_q <= axi_lite_cut_pkg::WR_IDLE;
      endcase
    end
  end

  // Read channel FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_q <= axi_lite_cut_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        axi_lite_cut_pkg::RD_IDLE: if (rd_fire) rd_state_q <= axi_lite_cut_pkg::RD_RESP;
        axi_lite_cut_pkg::RD_RESP: if (r_ready_i) rd_state_q <= axi_lite_cut_pkg::RD_IDLE;
        default: rd_state_q <= axi_lite_cut_pkg::RD_IDLE;
      endcase
    end
  end

  // Response payloads, captured when the request is taken
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_in_range ? axi_lite_cut_pkg::RESP_OKAY : axi_lite_cut_pkg::RESP_SLVERR;
    end
    if (rd_fire) begin
      r_data_q <= rd_in_range ? regs_q[rd_idx] : '0;
      r_resp_q <= rd_in_range ? axi_lite_cut_pkg::RESP_OKAY : axi_lite_cut_pkg::RESP_SLVERR;
    end
  end

endmodule

//--- src/spill_register.sv
`timescale 1ns/10ps

module spill_register #(
  parameter int unsigned width  = 1,
  parameter bit          bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [width-1:0] data_o
);

  if (bypass) begin : gen_bypass
    // Purely combinational, no cut at all
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_reg
    logic             out_full_q;
    logic             spill_full_q;
    logic [width-1:0] out_data_q;
    logic [width-1:0] spill_data_q;
    logic             in_fire;
    logic             out_free;

    // Upstream ready only looks at the spill slot
    assign ready_o = ~spill_full_q;
    assign valid_o = out_full_q;
    assign data_o  = out_data_q;

    assign in_fire  = valid_i & ~spill_full_q;
    // Output slot can take a new item on this edge
    assign out_free = ~out_full_q | ready_i;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        out_full_q   <= 1'b0;
        spill_full_q <= 1'b0;
      end else begin
        if (out_free) begin
          out_full_q <= spill_full_q | in_fire;
        end
        if (spill_full_q && out_free) begin
          spill_full_q <= 1'b0;
        end else if (in_fire && !out_free) begin
          spill_full_q <= 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      // Spilled item is older, so it goes out first
      if (out_free && (spill_full_q || in_fire)) begin
        out_data_q <= spill_full_q ? spill_data_q : data_i;
      end
      // Park the new item while the output slot is stalled
      if (in_fire && !out_free) begin
        spill_data_q <= data_i;
      end
    end
  end

endmodule

//--- test/axi_lite_cut_chain_props.sv
`timescale 1ns/10ps

module axi_lite_cut_chain_props (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    b_valid_i,
  input logic                    b_ready_i,
  input axi_lite_cut_pkg::resp_t b_resp_i,
  input logic                    r_valid_i,
  input logic                    r_ready_i,
  input axi_lite_cut_pkg::data_t r_data_i,
  input axi_lite_cut_pkg::resp_t r_resp_i
);

  // Write response held steady until taken
  b_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
    else $error("b_valid_o dropped or b_resp_o changed before b_ready_i");

  // Read response, data and code both
  r_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
    else $error("r_valid_o dropped or r_data_o/r_resp_o changed before r_ready_i");

  reset_idle_a: assert property (@(posedge clk_i)
    reset_i |=> !b_valid_i && !r_valid_i)
    else $error("valid output high in the cycle after reset_i");

endmodule

bind axi_lite_cut_chain axi_lite_cut_chain_props props_inst (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .b_valid_i (b_valid_o),
  .b_ready_i (b_ready_i),
  .b_resp_i  (b_resp_o),
  .r_valid_i (r_valid_o),
  .r_ready_i (r_ready_i),
  .r_data_i  (r_data_o),
  .r_resp_i  (r_resp_o)
);

//--- test/axi_lite_cut_chain_tb.sv
`timescale 1ns/10ps

module axi_lite_cut_chain_tb;

  localparam int num_cuts  = 2;
  localparam int num_regs  = 8;
  localparam int burst_len = 8;
  // Transactions over all tests, with a cycle budget per transaction
  localparam int num_txns   = num_regs + 2 * 200 + 2 * 30 + 3 * 16 + 100 + 4 * 2 * burst_len;
  localparam int max_cycles = num_txns * 6 * (2 * num_cuts + 1) + 2000;

  logic clk;
  logic reset;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  axi_lite_cut_pkg::addr_t aw_addr, ar_addr;
  axi_lite_cut_pkg::data_t w_data, r_data;
  axi_lite_cut_pkg::strb_t w_strb;
  axi_lite_cut_pkg::resp_t b_resp, r_resp;

  axi_lite_cut_pkg::data_t model [num_regs];
  logic [31:0] lcg_state = 32'h8d067b14;
  bit          bp_en;
  int          checks, errors, checks_start, errors_start, cycle_count;
  string       test_name;

  axi_lite_cut_chain #(
    .num_cuts (num_cuts),
    .bypass   (1'b0),
    .num_regs (num_regs)
  ) axi_lite_cut_chain_inst (
    .clk_i      (clk),
    .reset_i    (reset),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .b_resp_o   (b_resp),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Response ready, low on random cycles while back-pressure is on
  function logic pick_ready();
    logic [31:0] r;
    r = next_rand();
    return !bp_en || r[20];
  endfunction

  function automatic axi_lite_cut_pkg::addr_t addr_in_range();
    logic [31:0] r;
    r = next_rand();
    return axi_lite_cut_pkg::addr_t'(int'(r[31:16]) % num_regs * 4 + int'(r[9:8]));
  endfunction

  function automatic axi_lite_cut_pkg::addr_t addr_out_of_range();
    logic [31:0] r;
    r = next_rand();
    return axi_lite_cut_pkg::addr_t'(num_regs * 4 + int'(r[31:16]) % (4096 - num_regs * 4));
  endfunction

  function automatic bit in_range(axi_lite_cut_pkg::addr_t addr);
    return int'(addr[11:2]) < num_regs;
  endfunction

  // Model merges enabled byte lanes, out of range leaves it alone
  function automatic axi_lite_cut_pkg::resp_t model_write(axi_lite_cut_pkg::addr_t addr,
                                                          axi_lite_cut_pkg::data_t data,
                                                          axi_lite_cut_pkg::strb_t strb);
    int idx;
    idx = int'(addr[11:2]);
    if (!in_range(addr)) begin
      return axi_lite_cut_pkg::RESP_SLVERR;
    end
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
    end
    return axi_lite_cut_pkg::RESP_OKAY;
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic flag_error(string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic begin_test(string name);
    test_name    = name;
    checks_start = checks;
    errors_start = errors;
  endtask

  task automatic end_test();
    $display("Test %s done: %0d checks, %0d errors", test_name,
             checks - checks_start, errors - errors_start);
  endtask

  // AW and W offered together, each dropped after its own handshake
  task automatic send_write(input axi_lite_cut_pkg::addr_t addr,
                            input axi_lite_cut_pkg::data_t data,
                            input axi_lite_cut_pkg::strb_t strb);
    bit aw_done;
    bit w_done;
    aw_addr  = addr;
    w_data   = data;
    w_strb   = strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    while (aw_valid || w_valid) begin
      #1;
      aw_done = aw_valid && aw_ready;
      w_done  = w_valid && w_ready;
      @(posedge clk);
      #1;
      if (aw_done) aw_valid = 1'b0;
      if (w_done) w_valid = 1'b0;
    end
  endtask

  task automatic take_write_resp(output axi_lite_cut_pkg::resp_t resp);
    bit b_done;
    b_done = 1'b0;
    while (!b_done) begin
      b_ready = pick_ready();
      #1;
      b_done = b_valid && b_ready;
      resp   = b_resp;
      @(posedge clk);
      #1;
    end
    b_ready = 1'b0;
  endtask

  task automatic write_txn(input axi_lite_cut_pkg::addr_t addr,
                           input axi_lite_cut_pkg::data_t data,
                           input axi_lite_cut_pkg::strb_t strb,
                           output axi_lite_cut_pkg::resp_t resp);
    send_write(addr, data, strb);
    take_write_resp(resp);
    if (b_valid) flag_error("a second write response appeared");
  endtask

  task automatic send_read(input axi_lite_cut_pkg::addr_t addr);
    bit ar_done;
    ar_addr  = addr;
    ar_valid = 1'b1;
    while (ar_valid) begin
      #1;
      ar_done = ar_ready;
      @(posedge clk);
      #1;
      if (ar_done) ar_valid = 1'b0;
    end
  endtask

  task automatic take_read_resp(output axi_lite_cut_pkg::data_t data,
                                output axi_lite_cut_pkg::resp_t resp);
    bit r_done;
    r_done = 1'b0;
    while (!r_done) begin
      r_ready = pick_ready();
      #1;
      r_done = r_valid && r_ready;
      data   = r_data;
      resp   = r_resp;
      @(posedge clk);
      #1;
    end
    r_ready = 1'b0;
  endtask

  task automatic read_txn(input axi_lite_cut_pkg::addr_t addr,
                          output axi_lite_cut_pkg::data_t data,
                          output axi_lite_cut_pkg::resp_t resp);
    send_read(addr);
    take_read_resp(data, resp);
    if (r_valid) flag_error("a second read response appeared");
  endtask

  task automatic write_and_check(axi_lite_cut_pkg::addr_t addr,
                                 axi_lite_cut_pkg::data_t data,
                                 axi_lite_cut_pkg::strb_t strb);
    axi_lite_cut_pkg::resp_t resp;
    axi_lite_cut_pkg::resp_t exp_resp;
    write_txn(addr, data, strb, resp);
    exp_resp = model_write(addr, data, strb);
    check_value("b_resp", 32'(exp_resp), 32'(resp));
  endtask

  task automatic check_read(axi_lite_cut_pkg::addr_t addr,
                            axi_lite_cut_pkg::data_t data,
                            axi_lite_cut_pkg::resp_t resp);
    axi_lite_cut_pkg::data_t exp_data;
    axi_lite_cut_pkg::resp_t exp_resp;
    exp_data = in_range(addr) ? model[int'(addr[11:2])] : '0;
    exp_resp = in_range(addr) ? axi_lite_cut_pkg::RESP_OKAY : axi_lite_cut_pkg::RESP_SLVERR;
    check_value("r_data", exp_data, data);
    check_value("r_resp", 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_and_check(axi_lite_cut_pkg::addr_t addr);
    axi_lite_cut_pkg::data_t data;
    axi_lite_cut_pkg::resp_t resp;
    read_txn(addr, data, resp);
    check_read(addr, data, resp);
  endtask

  // Writes pile up behind a stalled B channel and fill the spill slots
  task automatic write_burst(int count);
    axi_lite_cut_pkg::resp_t exp_resp [$];
    axi_lite_cut_pkg::resp_t expected;
    axi_lite_cut_pkg::resp_t resp;
    axi_lite_cut_pkg::addr_t addr;
    axi_lite_cut_pkg::data_t data;
    logic [31:0] r;
    repeat (count) begin
      r    = next_rand();
      addr = r[31] ? addr_out_of_range() : addr_in_range();
      data = next_rand();
      send_write(addr, data, r[27:24]);
      exp_resp.push_back(model_write(addr, data, r[27:24]));
    end
    repeat (count) begin
      take_write_resp(resp);
      expected = exp_resp.pop_front();
      check_value("b_resp", 32'(expected), 32'(resp));
    end
    if (b_valid) flag_error("a second write response appeared");
  endtask

  // Reads pile up behind a stalled R channel, responses must keep their order
  task automatic read_burst(int count);
    axi_lite_cut_pkg::addr_t addrs [$];
    axi_lite_cut_pkg::addr_t addr;
    axi_lite_cut_pkg::data_t data;
    axi_lite_cut_pkg::resp_t resp;
    logic [31:0] r;
    repeat (count) begin
      r    = next_rand();
      addr = r[31] ? addr_out_of_range() : addr_in_range();
      send_read(addr);
      addrs.push_back(addr);
    end
    repeat (count) begin
      take_read_resp(data, resp);
      addr = addrs.pop_front();
      check_read(addr, data, resp);
    end
    if (r_valid) flag_error("a second read response appeared");
  endtask

  initial begin
    axi_lite_cut_pkg::addr_t addr;
    logic [31:0] r;
    reset    = 1'b1;
    aw_valid = 1'b0;
    aw_addr  = '0;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar_addr  = '0;
    r_ready  = 1'b0;
    bp_en    = 1'b0;
    for (int i = 0; i < num_regs; i++) model[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test("reset_state");
    for (int i = 0; i < num_regs; i++) read_and_check(axi_lite_cut_pkg::addr_t'(i * 4));
    end_test();

    begin_test("write_read");
    repeat (200) begin
      addr = addr_in_range();
      write_and_check(addr, next_rand(), 4'hf);
      read_and_check(addr);
    end
    end_test();

    begin_test("byte_strobes");
    repeat (30) begin
      r    = next_rand();
      addr = addr_in_range();
      write_and_check(addr, next_rand(), r[27:24]);
      read_and_check(addr);
    end
    end_test();

    // Also read the in-range word that shares the low index bits
    begin_test("out_of_range");
    repeat (16) begin
      addr = addr_out_of_range();
      write_and_check(addr, next_rand(), 4'hf);
      read_and_check(addr);
      read_and_check(axi_lite_cut_pkg::addr_t'(int'(addr[11:2]) % num_regs * 4));
    end
    end_test();

    begin_test("back_pressure");
    bp_en = 1'b1;
    repeat (100) begin
      r    = next_rand();
      addr = (r[31:29] == 3'd0) ? addr_out_of_range() : addr_in_range();
      if (r[28]) write_and_check(addr, next_rand(), r[27:24]);
      else read_and_check(addr);
    end
    repeat (4) begin
      write_burst(burst_len);
      read_burst(burst_len);
    end
    bp_en = 1'b0;
    end_test();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, a handshake or response never completed", cycle_count);
    $display("Errors found");
    $finish;
  end

endmodule
